/* all.f */
eeprom_bus_pkg.sv
i2c_pkg.sv
eeprom_cmd_if.sv
i2c_byte_if.sv
wb_eeprom_regs.sv
eeprom_seq.sv
i2c_byte_engine.sv
eeprom_ctrl_top.sv
tb_eeprom_model.sv
tb_eeprom_top.sv

/* eeprom_bus_pkg.sv */
package eeprom_bus_pkg;

    localparam int EE_ADDR_BITS = 11;  // 2 KB, 24C16 style

    // wishbone register offsets
    localparam logic [1:0] REG_ADDR    = 2'd0;  // address bits 7:0
    localparam logic [1:0] REG_DATA    = 2'd1;
    localparam logic [1:0] REG_CMD     = 2'd2;  // command on write, status on read
    localparam logic [1:0] REG_ADDR_HI = 2'd3;  // address bits 10:8 in lane bits 2:0

    // command write bits
    localparam int CMD_WRITE_BIT = 0;
    localparam int CMD_READ_BIT  = 1;  // wins if both are set

    // status read bits
    localparam int STAT_BUSY_BIT = 0;
    localparam int STAT_NACK_BIT = 1;
    localparam int STAT_DONE_BIT = 2;

    typedef logic [EE_ADDR_BITS-1:0] ee_addr_t;

endpackage

/* eeprom_cmd_if.sv */
`timescale 1ns/1ps

interface eeprom_cmd_if
    import eeprom_bus_pkg::*;
();

    // request side, from the register block
    logic       start;  // single cycle
    logic       is_read;
    ee_addr_t   addr;
    logic [7:0] wdata;

    // reply side, from the sequencer
    logic       busy;
    logic       done;   // single cycle, busy drops with it
    logic       nack;
    logic [7:0] rdata;

    modport host (
        output start, is_read, addr, wdata,
        input  busy, done, nack, rdata
    );

    modport seq (
        input  start, is_read, addr, wdata,
        output busy, done, nack, rdata
    );

endinterface

/* eeprom_ctrl_top.sv */
`timescale 1ns/1ps

module eeprom_ctrl_top #(
    parameter int CLK_DIV = 4  // clocks per quarter scl period
)
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [1:0] wb_adr,
    input  logic [7:0] wb_dat_w,
    output logic [7:0] wb_dat_r,
    output logic       wb_ack,
    output logic       scl,
    output logic       sda_pull,  // high drives sda low
    input  logic       sda_in
);

    eeprom_cmd_if u_cmd_if ();
    i2c_byte_if   u_byte_if ();

    wb_eeprom_regs u_regs (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .cmd      (u_cmd_if)
    );

    eeprom_seq u_seq (
        .CLK   (CLK),
        .RESET (RESET),
        .cmd   (u_cmd_if),
        .bus   (u_byte_if)
    );

    i2c_byte_engine #(
        .CLK_DIV (CLK_DIV)
    ) u_engine (
        .CLK      (CLK),
        .RESET    (RESET),
        .bus      (u_byte_if),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda_in)
    );

endmodule

/* eeprom_seq.sv */
`timescale 1ns/1ps

module eeprom_seq
    import eeprom_bus_pkg::*, i2c_pkg::*;
(
    input  logic CLK,
    input  logic RESET,
    eeprom_cmd_if.seq  cmd,
    i2c_byte_if.master bus
);

    typedef enum logic [3:0] {
        IDLE,
        START,
        CTRL_W,
        ADDR,
        DATA,
        RESTART,
        CTRL_R,
        READ,
        STOP,
        FINISH
    } seq_state_t;

    seq_state_t state;
    seq_state_t next_state;
    logic       waiting;  // op issued, engine busy
    logic       rd_r;
    ee_addr_t   addr_r;
    logic [7:0] wdata_r;

    assign bus.master_ack = 1'b0;  // single byte read ends with nack

    // operation and next step for the current state
    always_comb
    begin
        bus.op     = OP_WRITE;
        bus.txd    = 8'h00;
        next_state = IDLE;
        case (state)
            START:
            begin
                bus.op     = OP_START;
                next_state = CTRL_W;
            end
            CTRL_W:
            begin
                bus.txd    = {DEVICE_CODE, addr_r[EE_ADDR_BITS-1:8], DIR_WRITE};
                next_state = ADDR;
            end
            ADDR:
            begin
                bus.txd    = addr_r[7:0];
                next_state = rd_r ? RESTART : DATA;
            end
            DATA:
            begin
                bus.txd    = wdata_r;
                next_state = STOP;
            end
            RESTART:
            begin
                bus.op     = OP_START;
                next_state = CTRL_R;
            end
            CTRL_R:
            begin
                bus.txd    = {DEVICE_CODE, addr_r[EE_ADDR_BITS-1:8], DIR_READ};
                next_state = READ;
            end
            READ:
            begin
                bus.op     = OP_READ;
                next_state = STOP;
            end
            STOP:
            begin
                bus.op     = OP_STOP;
                next_state = FINISH;
            end
            default: ;
        endcase
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= IDLE;
            waiting  <= 1'b0;
            rd_r     <= 1'b0;
            bus.go   <= 1'b0;
            cmd.busy <= 1'b0;
            cmd.done <= 1'b0;
            cmd.nack <= 1'b0;
        end
        else
        begin
            bus.go   <= 1'b0;
            cmd.done <= 1'b0;
            case (state)
                IDLE:
                    if (cmd.start)
                    begin
                        cmd.busy <= 1'b1;
                        cmd.nack <= 1'b0;
                        rd_r     <= cmd.is_read;
                        state    <= START;
                    end
                FINISH:
                begin
                    cmd.done <= 1'b1;
                    cmd.busy <= 1'b0;
                    state    <= IDLE;
                end
                default:
                    if (!waiting)
                    begin
                        if (bus.ready)
                        begin
                            bus.go  <= 1'b1;
                            waiting <= 1'b1;
                        end
                    end
                    else if (bus.done)
                    begin
                        waiting <= 1'b0;
                        if (bus.op == OP_WRITE && !bus.slave_ack)
                        begin
                            cmd.nack <= 1'b1;  // abort, still close the bus
                            state    <= STOP;
                        end
                        else
                            state <= next_state;
                    end
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (state == IDLE && cmd.start)
        begin
            addr_r  <= cmd.addr;
            wdata_r <= cmd.wdata;
        end
        if (state == READ && bus.done)
            cmd.rdata <= bus.rxd;
    end

    a_go_when_ready: assert property (@(posedge CLK) disable iff (RESET)
        bus.go |-> bus.ready);

endmodule

/* i2c_byte_engine.sv */
`timescale 1ns/1ps

module i2c_byte_engine
    import i2c_pkg::*;
#(
    parameter int CLK_DIV = 4
)
(
    input  logic CLK,
    input  logic RESET,
    i2c_byte_if.engine bus,
    output logic scl,
    output logic sda_pull,
    input  logic sda_in
);

    localparam int QW = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

    logic [QW-1:0] q_cnt;    // clocks within a quarter
    logic [1:0]    phase;    // quarter of the scl period
    logic [3:0]    bit_cnt;
    byte_op_t      op_r;
    logic          ack_r;
    logic [7:0]    shreg;    // out on write, in on read
    logic          tick;
    logic          last_bit;

    // scl and pull level for one quarter
    // byte bits are low, high, high, low on scl
    function automatic logic [1:0] line_levels(byte_op_t op, logic [1:0] ph, logic pull);
        logic clk_hi;
        clk_hi = (ph == 2'd1) || (ph == 2'd2);
        case (op)
            OP_START: line_levels = {clk_hi, ph[1]};       // release, then fall with scl high
            OP_STOP:  line_levels = {ph != 2'd0, !ph[1]};  // pull, then rise with scl high
            default:  line_levels = {clk_hi, pull};
        endcase
    endfunction

    // sda pull level held for a whole bit of a byte transfer
    function automatic logic bit_pull(byte_op_t op, logic [3:0] idx, logic msb, logic mack);
        if (idx == 4'(XFER_BITS - 1))
            bit_pull = (op == OP_READ) && mack;
        else
            bit_pull = (op == OP_WRITE) && !msb;
    endfunction

    assign tick     = (q_cnt == QW'(CLK_DIV - 1));
    assign last_bit = (op_r == OP_START) || (op_r == OP_STOP)
                      || (bit_cnt == 4'(XFER_BITS - 1));
    assign bus.rxd  = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            bus.ready     <= 1'b1;
            bus.done      <= 1'b0;
            bus.slave_ack <= 1'b0;
            scl           <= 1'b1;  // bus idle
            sda_pull      <= 1'b0;
            q_cnt         <= '0;
            phase         <= 2'd0;
            bit_cnt       <= 4'd0;
            op_r          <= OP_STOP;
            ack_r         <= 1'b0;
        end
        else
        begin
            bus.done <= 1'b0;
            if (bus.ready)
            begin
                if (bus.go)
                begin
                    bus.ready <= 1'b0;
                    op_r      <= bus.op;
                    ack_r     <= bus.master_ack;
                    q_cnt     <= '0;
                    phase     <= 2'd0;
                    bit_cnt   <= 4'd0;
                    {scl, sda_pull} <= line_levels(bus.op, 2'd0,
                        bit_pull(bus.op, 4'd0, bus.txd[7], bus.master_ack));
                end
            end
            else if (tick)
            begin
                q_cnt <= '0;
                // ack sampled at the scl high midpoint
                if (phase == 2'd1 && bit_cnt == 4'(XFER_BITS - 1))
                    bus.slave_ack <= !sda_in;
                if (phase == 2'd3)
                begin
                    if (last_bit)
                    begin
                        bus.ready <= 1'b1;
                        bus.done  <= 1'b1;
                    end
                    else
                    begin
                        bit_cnt <= bit_cnt + 4'd1;
                        phase   <= 2'd0;
                        {scl, sda_pull} <= line_levels(op_r, 2'd0,
                            bit_pull(op_r, bit_cnt + 4'd1, shreg[7], ack_r));
                    end
                end
                else
                begin
                    phase <= phase + 2'd1;
                    {scl, sda_pull} <= line_levels(op_r, phase + 2'd1, sda_pull);
                end
            end
            else
                q_cnt <= q_cnt + QW'(1);
        end
    end

    // msb first, data bits sampled at the scl high midpoint
    always_ff @(posedge CLK)
    begin
        if (bus.ready && bus.go)
            shreg <= bus.txd;
        else if (!bus.ready && tick && phase == 2'd1 && bit_cnt < 4'(XFER_BITS - 1))
            shreg <= {shreg[6:0], sda_in};
    end

    // sda only moves under a high scl for start and stop
    a_sda_stable: assert property (@(posedge CLK) disable iff (RESET)
        ($changed(sda_pull) && scl && $past(scl)) |-> (op_r inside {OP_START, OP_STOP}));

endmodule

/* i2c_byte_if.sv */
`timescale 1ns/1ps

interface i2c_byte_if
    import i2c_pkg::*;
();

    // operation request
    logic       go;          // only while ready
    byte_op_t   op;
    logic [7:0] txd;
    logic       master_ack;  // 1 pulls sda low in the ack slot of a read

    // engine reply
    logic       ready;
    logic       done;        // single cycle, ready rises with it
    logic [7:0] rxd;
    logic       slave_ack;   // 1 = slave pulled sda low

    modport master (
        output go, op, txd, master_ack,
        input  ready, done, rxd, slave_ack
    );

    modport engine (
        input  go, op, txd, master_ack,
        output ready, done, rxd, slave_ack
    );

endinterface

/* i2c_pkg.sv */
package i2c_pkg;

    // fixed upper nibble of the control byte
    localparam logic [3:0] DEVICE_CODE = 4'b1010;

    // r/w bit, lsb of the control byte
    localparam logic DIR_WRITE = 1'b0;
    localparam logic DIR_READ  = 1'b1;

    localparam int XFER_BITS = 9;  // 8 data + ack

    // one engine operation each
    typedef enum logic [1:0] {
        OP_START,
        OP_STOP,
        OP_WRITE,
        OP_READ
    } byte_op_t;

endpackage

/* run.sh */
#!/bin/sh
# build with verilator, pass only if the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f all.f --top-module tb_eeprom_top -o tb_sim &&
./obj_dir/tb_sim | awk '{ print } /^All tests passed!$/ { ok = 1 } END { exit !ok }' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

/* tb_eeprom_model.sv */
`timescale 1ns/1ps

module tb_eeprom_model
    import i2c_pkg::*;
(
    input  logic CLK,
    input  logic scl,
    input  logic sda,         // resolved bus line
    input  logic nack_force,
    output logic sda_pull,    // high pulls sda low
    output int   frame_errors,
    output int   stop_count
);

    logic [7:0]  mem [0:2047];
    logic        scl_q;
    logic        sda_q;
    logic        active;      // between start and stop
    logic        sending;     // slave owns sda for a read byte
    logic        rd_pending;
    logic [3:0]  bit_cnt;     // scl rises seen in this byte
    logic [1:0]  byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  tx_byte;
    logic [10:0] ptr;

    task automatic flag_framing(input string what);
        frame_errors <= frame_errors + 1;
        $display("framing error at %0t ns: %s", $time, what);
    endtask

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;  // power-up contents
        scl_q        = 1'b1;
        sda_q        = 1'b1;
        active       = 1'b0;
        sending      = 1'b0;
        rd_pending   = 1'b0;
        bit_cnt      = 4'd0;
        byte_idx     = 2'd0;
        shreg        = 8'h00;
        tx_byte      = 8'h00;
        ptr          = '0;
        sda_pull     = 1'b0;
        frame_errors = 0;
        stop_count   = 0;
    end

    // lines sampled once per clock, edges found against the last sample
    always @(posedge CLK)
    begin
        logic ack;
        ack = !nack_force && (shreg[7:4] == DEVICE_CODE || byte_idx != 2'd0);
        scl_q <= scl;
        sda_q <= sda;
        if (scl_q && scl && sda_q && !sda)
        begin
            // first bit's scl high is shared with a start
            if (bit_cnt > 4'd1)
                flag_framing("start inside a byte");
            active     <= 1'b1;
            sending    <= 1'b0;
            rd_pending <= 1'b0;
            sda_pull   <= 1'b0;
            bit_cnt    <= 4'd0;
            byte_idx   <= 2'd0;
        end
        else if (scl_q && scl && !sda_q && sda)
        begin
            if (bit_cnt > 4'd1 || !active)
                flag_framing("stop inside a byte or without a start");
            stop_count <= stop_count + 1;
            active     <= 1'b0;
            sending    <= 1'b0;
            sda_pull   <= 1'b0;
            bit_cnt    <= 4'd0;
        end
        else if (active && !scl_q && scl)
        begin
            if (bit_cnt < 4'd8)
                shreg <= {shreg[6:0], sda};
            bit_cnt <= bit_cnt + 4'd1;
        end
        else if (active && scl_q && !scl)
        begin
            if (bit_cnt == 4'd8 && sending)
                sda_pull <= 1'b0;  // master ack slot
            else if (bit_cnt == 4'd8)
            begin
                sda_pull <= ack;
                byte_idx <= byte_idx + 2'd1;
                case (byte_idx)
                    2'd0:
                    begin
                        ptr[10:8]  <= shreg[3:1];
                        tx_byte    <= mem[{shreg[3:1], ptr[7:0]}];
                        rd_pending <= ack && (shreg[0] == DIR_READ);
                    end
                    2'd1:
                        if (ack)
                            ptr[7:0] <= shreg;
                    2'd2:
                        if (ack)
                            mem[ptr] <= shreg;
                    default:
                        flag_framing("more than one data byte");
                endcase
            end
            else if (bit_cnt == 4'd9)
            begin
                bit_cnt    <= 4'd0;
                sending    <= rd_pending;
                rd_pending <= 1'b0;
                sda_pull   <= rd_pending && !tx_byte[7];  // msb of the read byte
            end
            else if (sending && bit_cnt != 4'd0)
                sda_pull <= !tx_byte[3'(7 - bit_cnt)];
        end
    end

endmodule

/* tb_eeprom_top.sv */
`timescale 1ns/1ps

module tb_eeprom_top
    import eeprom_bus_pkg::*;
();

    localparam int CLK_DIV    = 2;
    localparam int NUM_ROWS   = 22;
    localparam int MAX_CYCLES = NUM_ROWS * 2 * 50 * 4 * CLK_DIV + 10000;

    logic       CLK;
    logic       RESET;
    logic       wb_cyc;
    logic       wb_stb;
    logic       wb_we;
    logic [1:0] wb_adr;
    logic [7:0] wb_dat_w;
    logic [7:0] wb_dat_r;
    logic       wb_ack;
    logic       scl;
    logic       sda_pull;
    logic       model_pull;
    logic       nack_force;
    wire        sda;
    int         frame_errors;
    int         stop_count;

    // stimulus table with one transaction per row
    logic       row_rd   [NUM_ROWS];
    ee_addr_t   row_addr [NUM_ROWS];
    logic [7:0] row_data [NUM_ROWS];
    logic       row_nack [NUM_ROWS];
    logic [7:0] exp_data [NUM_ROWS];
    logic       exp_nack [NUM_ROWS];
    logic [7:0] mirror   [0:2047];
    int         n_rows;
    int         seed;
    int         errors;
    int         checks;
    int         cycles;

    assign sda = !(sda_pull || model_pull);  // wired and

    eeprom_ctrl_top #(
        .CLK_DIV (CLK_DIV)
    ) u_dut (
        .CLK      (CLK),
        .RESET    (RESET),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack),
        .scl      (scl),
        .sda_pull (sda_pull),
        .sda_in   (sda)
    );

    tb_eeprom_model u_model (
        .CLK          (CLK),
        .scl          (scl),
        .sda          (sda),
        .nack_force   (nack_force),
        .sda_pull     (model_pull),
        .frame_errors (frame_errors),
        .stop_count   (stop_count)
    );

    initial
    begin
        CLK = 1'b0;
        forever #10 CLK = ~CLK;
    end

    always @(posedge CLK)
    begin
        cycles <= cycles + 1;
        if (cycles > MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("Test failures found");
            $finish;
        end
    end

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("error at %0t ns: %s = %0h, expected %0h", $time, name, got, exp);
        end
    endtask

    // classic cycle, stb stays up until the ack clock has passed
    task automatic write_reg(input logic [1:0] adr, input logic [7:0] d);
        @(posedge CLK);
        #1;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = d;
        @(posedge CLK);
        #1;
        check("wb_ack", 32'(wb_ack), 32'd1);
        @(posedge CLK);
        #1;
        check("wb_ack", 32'(wb_ack), 32'd0);  // single cycle ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic read_reg(input logic [1:0] adr, output logic [7:0] d);
        @(posedge CLK);
        #1;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(posedge CLK);
        #1;
        check("wb_ack", 32'(wb_ack), 32'd1);
        d = wb_dat_r;
        @(posedge CLK);
        #1;
        check("wb_ack", 32'(wb_ack), 32'd0);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic set_address(input ee_addr_t a);
        logic [7:0] rd;
        write_reg(REG_ADDR, a[7:0]);
        write_reg(REG_ADDR_HI, 8'(a[10:8]));
        read_reg(REG_ADDR, rd);
        check("address low", 32'(rd), 32'(a[7:0]));
        read_reg(REG_ADDR_HI, rd);
        check("address high", 32'(rd), 32'(a[10:8]));
    endtask

    // poll status until busy clears and done is set
    task automatic wait_done(output logic [7:0] st);
        read_reg(REG_CMD, st);
        while (st[STAT_BUSY_BIT] || !st[STAT_DONE_BIT])
            read_reg(REG_CMD, st);
    endtask

    task automatic issue_command(input logic rd, output logic [7:0] st);
        write_reg(REG_CMD, rd ? 8'(1 << CMD_READ_BIT) : 8'(1 << CMD_WRITE_BIT));
        wait_done(st);
    endtask

    task automatic add_row(input logic rd, input ee_addr_t a, input logic [7:0] d,
                           input logic nf);
        row_rd[n_rows]   = rd;
        row_addr[n_rows] = a;
        row_data[n_rows] = d;
        row_nack[n_rows] = nf;
        exp_nack[n_rows] = nf;
        if (rd)
            exp_data[n_rows] = mirror[a];
        else
        begin
            exp_data[n_rows] = d;  // data register keeps the host value
            if (!nf)
                mirror[a] = d;
        end
        n_rows++;
    endtask

    task automatic build_table();
        ee_addr_t blk_addr [8];
        ee_addr_t a;
        for (int b = 0; b < 8; b++)
        begin
            blk_addr[b] = {3'(b), 8'($random(seed))};
            add_row(1'b0, blk_addr[b], 8'($random(seed)), 1'b0);
        end
        for (int b = 0; b < 8; b++)
            add_row(1'b1, blk_addr[b], 8'h00, 1'b0);
        add_row(1'b0, blk_addr[0], ~mirror[blk_addr[0]], 1'b1);  // refused by the slave
        add_row(1'b1, blk_addr[0], 8'h00, 1'b0);
        for (int k = 0; k < 2; k++)
        begin
            a = 11'($random(seed));
            add_row(1'b0, a, 8'($random(seed)), 1'b0);
            add_row(1'b1, a, 8'h00, 1'b0);
        end
    endtask

    task automatic run_row(input int r);
        logic [7:0] st;
        logic [7:0] rd;
        int         stops_before;
        set_address(row_addr[r]);
        if (!row_rd[r])
            write_reg(REG_DATA, row_data[r]);
        nack_force   = row_nack[r];
        stops_before = stop_count;
        issue_command(row_rd[r], st);
        check("status nack", 32'(st[STAT_NACK_BIT]), 32'(exp_nack[r]));
        check("stop count", 32'(stop_count), 32'(stops_before + 1));
        check("scl", 32'(scl), 32'd1);
        check("sda_pull", 32'(sda_pull), 32'd0);
        read_reg(REG_DATA, rd);
        check("data register", 32'(rd), 32'(exp_data[r]));
        nack_force = 1'b0;
    endtask

    task automatic check_reset_state();
        logic [7:0] rd;
        check("scl", 32'(scl), 32'd1);
        check("sda_pull", 32'(sda_pull), 32'd0);
        read_reg(REG_CMD, rd);
        check("status", 32'(rd), 32'd0);
        read_reg(REG_ADDR, rd);
        check("address low", 32'(rd), 32'd0);
        read_reg(REG_ADDR_HI, rd);
        check("address high", 32'(rd), 32'd0);
        read_reg(REG_DATA, rd);
        check("data register", 32'(rd), 32'd0);
    endtask

    // second command lands while the first is still on the bus
    task automatic busy_command_test();
        ee_addr_t   a;
        logic [7:0] st;
        logic [7:0] rd;
        int         stops_before;
        a = 11'h2c5;
        set_address(a);
        write_reg(REG_DATA, 8'h3c);
        stops_before = stop_count;
        write_reg(REG_CMD, 8'(1 << CMD_WRITE_BIT));
        read_reg(REG_CMD, st);
        check("status busy", 32'(st[STAT_BUSY_BIT]), 32'd1);
        write_reg(REG_DATA, 8'hc3);
        write_reg(REG_CMD, 8'(1 << CMD_WRITE_BIT));
        wait_done(st);
        mirror[a] = 8'h3c;
        repeat (50 * 4 * CLK_DIV)
            @(posedge CLK);
        read_reg(REG_CMD, st);
        check("status busy", 32'(st[STAT_BUSY_BIT]), 32'd0);
        check("status done", 32'(st[STAT_DONE_BIT]), 32'd1);
        check("stop count", 32'(stop_count), 32'(stops_before + 1));
        issue_command(1'b1, st);
        read_reg(REG_DATA, rd);
        check("data register", 32'(rd), 32'(mirror[a]));
    endtask

    initial
    begin
        RESET      = 1'b1;
        wb_cyc     = 1'b0;
        wb_stb     = 1'b0;
        wb_we      = 1'b0;
        wb_adr     = 2'd0;
        wb_dat_w   = 8'h00;
        nack_force = 1'b0;
        errors     = 0;
        checks     = 0;
        cycles     = 0;
        n_rows     = 0;
        seed       = 32'h184c_bbcc;
        for (int i = 0; i < 2048; i++)
            mirror[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;  // model power-up contents
        build_table();
        repeat (2)
            @(posedge CLK);
        #1;
        RESET = 1'b0;
        check_reset_state();
        for (int r = 0; r < n_rows; r++)
            run_row(r);
        busy_command_test();
        check("framing errors", 32'(frame_errors), 32'd0);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

/* wb_eeprom_regs.sv */
`timescale 1ns/1ps

module wb_eeprom_regs
    import eeprom_bus_pkg::*;
(
    input  logic       CLK,
    input  logic       RESET,
    input  logic       wb_cyc,
    input  logic       wb_stb,
    input  logic       wb_we,
    input  logic [1:0] wb_adr,
    input  logic [7:0] wb_dat_w,
    output logic [7:0] wb_dat_r,
    output logic       wb_ack,
    eeprom_cmd_if.host cmd
);

    logic       access;
    logic       wr_en;
    logic       launch;
    ee_addr_t   addr_r;
    logic [7:0] data_r;
    logic       done_flag;
    logic       nack_flag;
    logic [7:0] status;

    assign access = wb_cyc && wb_stb && !wb_ack;  // one ack per access
    assign wr_en  = access && wb_we;

    // commands while busy are acked and dropped
    assign launch = wr_en && (wb_adr == REG_CMD) && !cmd.busy
                    && (wb_dat_w[CMD_WRITE_BIT] || wb_dat_w[CMD_READ_BIT]);

    assign cmd.addr  = addr_r;
    assign cmd.wdata = data_r;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            wb_ack      <= 1'b0;
            cmd.start   <= 1'b0;
            cmd.is_read <= 1'b0;
            addr_r      <= '0;
            data_r      <= '0;
            done_flag   <= 1'b0;
            nack_flag   <= 1'b0;
        end
        else
        begin
            wb_ack    <= access;
            cmd.start <= launch;
            if (launch)
            begin
                cmd.is_read <= wb_dat_w[CMD_READ_BIT];
                done_flag   <= 1'b0;
                nack_flag   <= 1'b0;
            end
            else if (cmd.done)
            begin
                done_flag <= 1'b1;
                nack_flag <= cmd.nack;
            end
            if (wr_en && wb_adr == REG_ADDR)
                addr_r[7:0] <= wb_dat_w;
            if (wr_en && wb_adr == REG_ADDR_HI)
                addr_r[EE_ADDR_BITS-1:8] <= wb_dat_w[EE_ADDR_BITS-9:0];
            // read result lands in the shared data register
            if (cmd.done && cmd.is_read && !cmd.nack)
                data_r <= cmd.rdata;
            else if (wr_en && wb_adr == REG_DATA)
                data_r <= wb_dat_w;
        end
    end

    always_comb
    begin
        status = 8'h00;
        status[STAT_BUSY_BIT] = cmd.busy;
        status[STAT_NACK_BIT] = nack_flag;
        status[STAT_DONE_BIT] = done_flag;
        wb_dat_r = 8'h00;
        case (wb_adr)
            REG_ADDR:    wb_dat_r = addr_r[7:0];
            REG_DATA:    wb_dat_r = data_r;
            REG_CMD:     wb_dat_r = status;
            REG_ADDR_HI: wb_dat_r = 8'(addr_r[EE_ADDR_BITS-1:8]);
        endcase
    end

    // master must hold stb until it sees ack
    a_ack_with_stb: assert property (@(posedge CLK) disable iff (RESET)
        wb_ack |-> wb_stb);

endmodule
